// File: design/lc3b_pkg.sv
package lc3b_pkg;

	localparam int WORD_W = 16;	// Data and instruction width.
	localparam int REG_AW = 3;	// Eight general-purpose registers.

	// Operate opcodes handled by the unit.
	localparam logic [3:0] op_add = 4'b0001;
	localparam logic [3:0] op_and = 4'b0101;
	localparam logic [3:0] op_not = 4'b1001;
	localparam logic [3:0] op_shf = 4'b1101;

	localparam logic [2:0] alu_add  = 3'd0;
	localparam logic [2:0] alu_and  = 3'd1;
	localparam logic [2:0] alu_not  = 3'd2;
	localparam logic [2:0] alu_pass = 3'd3;
	localparam logic [2:0] alu_sll  = 3'd4;
	localparam logic [2:0] alu_srl  = 3'd5;
	localparam logic [2:0] alu_sra  = 3'd6;

	// Bit positions in the one-hot condition code.
	localparam int CC_N = 2;
	localparam int CC_Z = 1;
	localparam int CC_P = 0;

	typedef struct packed {
		logic [3:0]        opcode;
		logic [REG_AW-1:0] dr;
		logic [REG_AW-1:0] sr1;
		logic              imm_mode;	// Set selects imm5 over sr2.
		logic [4:0]        low;		// imm5, or sr2 in its low three bits.
	} operate_t;

	typedef struct packed {
		logic [3:0]        opcode;
		logic [REG_AW-1:0] dr;
		logic [REG_AW-1:0] sr1;
		logic              dir;		// Clear shifts left.
		logic              arith;	// Set keeps the sign on a right shift.
		logic [3:0]        amount;
	} shift_t;

	// One instruction word seen through either field layout.
	typedef union packed {
		operate_t op;
		shift_t   shf;
	} lc3b_instr;

endpackage : lc3b_pkg

// File: design/gen_control.sv
module gen_control (
	input  lc3b_pkg::lc3b_instr instr,
	output logic [2:0]          aluop,
	output logic                imm_sel,
	output logic                is_shift,
	output logic                reg_load
);

	always_comb begin
		// Defaults describe an instruction that is dropped.
		aluop    = lc3b_pkg::alu_add;
		imm_sel  = 1'b0;
		is_shift = 1'b0;
		reg_load = 1'b0;

		case (instr.op.opcode)
			lc3b_pkg::op_add: begin
				imm_sel  = instr.op.imm_mode;	// Bit 5 picks imm5 or sr2.
				reg_load = 1'b1;
			end
			lc3b_pkg::op_and: begin
				aluop    = lc3b_pkg::alu_and;
				imm_sel  = instr.op.imm_mode;
				reg_load = 1'b1;
			end
			lc3b_pkg::op_not: begin
				aluop    = lc3b_pkg::alu_not;
				reg_load = 1'b1;
			end
			lc3b_pkg::op_shf: begin
				is_shift = 1'b1;
				reg_load = 1'b1;
				if (!instr.shf.dir) begin
					aluop = lc3b_pkg::alu_sll;
				end else if (!instr.shf.arith) begin
					aluop = lc3b_pkg::alu_srl;
				end else begin
					aluop = lc3b_pkg::alu_sra;	// Right shift with sign fill.
				end
			end
			default: begin
				// Branches, loads, stores and traps keep the defaults.
			end
		endcase
	end

endmodule : gen_control

// File: design/exec_sequencer.sv
module exec_sequencer (
	input  logic clk,
	input  logic rst_n,
	input  logic instr_valid,
	input  logic res_ready,
	input  logic reg_load,
	input  logic is_shift,
	input  logic shift_done,
	output logic instr_ready,
	output logic res_valid,
	output logic accept,
	output logic exec,
	output logic shift_step,
	output logic writeback
);

	localparam logic [1:0] IDLE   = 2'd0;
	localparam logic [1:0] EXEC   = 2'd1;
	localparam logic [1:0] SHIFT  = 2'd2;
	localparam logic [1:0] RESULT = 2'd3;

	logic [1:0] state;
	logic [1:0] state_next;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (instr_valid) begin
					state_next = EXEC;
				end
			end
			EXEC: begin
				if (!reg_load) begin
					state_next = IDLE;	// Dropped opcode, no result.
				end else if (is_shift && !shift_done) begin
					state_next = SHIFT;
				end else begin
					state_next = RESULT;	// Amount 0 goes straight out.
				end
			end
			SHIFT: begin
				if (shift_done) begin
					state_next = RESULT;
				end
			end
			RESULT: begin
				if (res_ready) begin
					state_next = IDLE;
				end
			end
			default: begin
				state_next = IDLE;
			end
		endcase
	end

	assign instr_ready = (state == IDLE);
	assign res_valid   = (state == RESULT);
	assign exec        = (state == EXEC);
	assign shift_step  = (state == SHIFT);
	assign accept      = instr_valid & instr_ready;	// Input handshake.
	assign writeback   = res_valid & res_ready;		// Result handshake.

endmodule : exec_sequencer

// File: design/shift_counter.sv
module shift_counter (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       load,
	input  logic       step,
	input  logic [3:0] amount,
	output logic       shift_done
);

	logic [3:0] count;
	logic [3:0] count_next;

	always_comb begin
		count_next = count;
		if (load) begin
			count_next = amount;
		end else if (step && (count != 4'd0)) begin
			count_next = count - 4'd1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count <= 4'd0;
		end else begin
			count <= count_next;
		end
	end

	// Looks at the count the coming edge will hold, so a zero amount is seen in the load cycle.
	assign shift_done = (count_next == 4'd0);

endmodule : shift_counter

// File: design/reg_state.sv
module reg_state (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [lc3b_pkg::REG_AW-1:0]   rd_addr1,
	input  logic [lc3b_pkg::REG_AW-1:0]   rd_addr2,
	input  logic                          wr_en,
	input  logic [lc3b_pkg::REG_AW-1:0]   wr_addr,
	input  logic [lc3b_pkg::WORD_W-1:0]   wr_data,
	input  logic [2:0]                    cc_in,
	output logic [lc3b_pkg::WORD_W-1:0]   rd_data1,
	output logic [lc3b_pkg::WORD_W-1:0]   rd_data2,
	output logic [2:0]                    cc
);

	localparam int NUM_REGS = 1 << lc3b_pkg::REG_AW;

	logic [lc3b_pkg::WORD_W-1:0] regs [NUM_REGS];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
			cc <= 3'(1 << lc3b_pkg::CC_Z);	// All registers read as zero.
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
			cc            <= cc_in;
		end
	end

	assign rd_data1 = regs[rd_addr1];
	assign rd_data2 = regs[rd_addr2];

endmodule : reg_state

// File: design/alu_shifter.sv
module alu_shifter (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          load_ops,
	input  logic                          exec,
	input  logic                          shift_step,
	input  logic [2:0]                    aluop,
	input  logic                          imm_sel,
	input  lc3b_pkg::lc3b_instr           instr,
	input  logic [lc3b_pkg::WORD_W-1:0]   src1,
	input  logic [lc3b_pkg::WORD_W-1:0]   src2,
	output lc3b_pkg::lc3b_instr           instr_q,
	output logic [lc3b_pkg::REG_AW-1:0]   dr,
	output logic [3:0]                    amount,
	output logic [lc3b_pkg::WORD_W-1:0]   result,
	output logic [2:0]                    result_cc
);

	logic [lc3b_pkg::WORD_W-1:0] op1;
	logic [lc3b_pkg::WORD_W-1:0] op2;
	logic [lc3b_pkg::WORD_W-1:0] opb;
	logic [lc3b_pkg::WORD_W-1:0] alu_out;
	logic [4:0]                  imm5;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			instr_q <= '0;
		end else if (load_ops) begin
			instr_q <= instr;
		end
	end

	always_ff @(posedge clk) begin
		if (load_ops) begin
			op1 <= src1;	// Read from addresses of the incoming word.
			op2 <= src2;
		end
	end

	assign dr     = instr_q.op.dr;
	assign amount = instr_q.shf.amount;
	assign imm5   = instr_q.op.low;
	assign opb    = imm_sel ? {{(lc3b_pkg::WORD_W - 5){imm5[4]}}, imm5} : op2;

	always_comb begin
		case (aluop)
			lc3b_pkg::alu_add: alu_out = op1 + opb;
			lc3b_pkg::alu_and: alu_out = op1 & opb;
			lc3b_pkg::alu_not: alu_out = ~op1;
			default:           alu_out = op1;	// Shifts start from the unshifted source.
		endcase
	end

	always_ff @(posedge clk) begin
		if (exec) begin
			result <= alu_out;
		end else if (shift_step) begin
			case (aluop)
				lc3b_pkg::alu_sll: result <= {result[lc3b_pkg::WORD_W-2:0], 1'b0};
				lc3b_pkg::alu_srl: result <= {1'b0, result[lc3b_pkg::WORD_W-1:1]};
				lc3b_pkg::alu_sra: result <= {result[lc3b_pkg::WORD_W-1],
					result[lc3b_pkg::WORD_W-1:1]};
				default:           result <= result;
			endcase
		end
	end

	always_comb begin
		result_cc = 3'b000;
		if (result[lc3b_pkg::WORD_W-1]) begin
			result_cc[lc3b_pkg::CC_N] = 1'b1;
		end else if (result == '0) begin
			result_cc[lc3b_pkg::CC_Z] = 1'b1;
		end else begin
			result_cc[lc3b_pkg::CC_P] = 1'b1;
		end
	end

endmodule : alu_shifter

// File: design/exec_unit.sv
module exec_unit (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          instr_valid,
	output logic                          instr_ready,
	input  lc3b_pkg::lc3b_instr           instr,
	output logic                          res_valid,
	input  logic                          res_ready,
	output logic [lc3b_pkg::REG_AW-1:0]   res_dr,
	output logic [lc3b_pkg::WORD_W-1:0]   res_data,
	output logic [2:0]                    res_cc
);

	lc3b_pkg::lc3b_instr         instr_q;
	logic [2:0]                  aluop;
	logic                        imm_sel;
	logic                        is_shift;
	logic                        reg_load;
	logic                        accept;
	logic                        exec;
	logic                        shift_step;
	logic                        writeback;
	logic                        shift_done;
	logic [3:0]                  shift_amount;
	logic [lc3b_pkg::WORD_W-1:0] src1;
	logic [lc3b_pkg::WORD_W-1:0] src2;

	gen_control i_gen_control (
		.instr    (instr_q),
		.aluop    (aluop),
		.imm_sel  (imm_sel),
		.is_shift (is_shift),
		.reg_load (reg_load)
	);

	exec_sequencer i_exec_sequencer (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.res_ready   (res_ready),
		.reg_load    (reg_load),
		.is_shift    (is_shift),
		.shift_done  (shift_done),
		.instr_ready (instr_ready),
		.res_valid   (res_valid),
		.accept      (accept),
		.exec        (exec),
		.shift_step  (shift_step),
		.writeback   (writeback)
	);

	shift_counter i_shift_counter (
		.clk        (clk),
		.rst_n      (rst_n),
		.load       (exec),
		.step       (shift_step),
		.amount     (shift_amount),
		.shift_done (shift_done)
	);

	reg_state i_reg_state (
		.clk      (clk),
		.rst_n    (rst_n),
		.rd_addr1 (instr.op.sr1),	// Sources are read before the word is latched.
		.rd_addr2 (instr.op.low[lc3b_pkg::REG_AW-1:0]),
		.wr_en    (writeback),
		.wr_addr  (res_dr),
		.wr_data  (res_data),
		.cc_in    (res_cc),
		.rd_data1 (src1),
		.rd_data2 (src2),
		.cc       ()		// No operate instruction reads the condition code.
	);

	alu_shifter i_alu_shifter (
		.clk        (clk),
		.rst_n      (rst_n),
		.load_ops   (accept),
		.exec       (exec),
		.shift_step (shift_step),
		.aluop      (aluop),
		.imm_sel    (imm_sel),
		.instr      (instr),
		.src1       (src1),
		.src2       (src2),
		.instr_q    (instr_q),
		.dr         (res_dr),
		.amount     (shift_amount),
		.result     (res_data),
		.result_cc  (res_cc)
	);

endmodule : exec_unit

// File: test/exec_unit_chk.sv
module exec_unit_chk (
	input logic                        clk,
	input logic                        rst_n,
	input logic                        instr_ready,
	input logic                        res_valid,
	input logic                        res_ready,
	input logic [lc3b_pkg::REG_AW-1:0] res_dr,
	input logic [lc3b_pkg::WORD_W-1:0] res_data,
	input logic [2:0]                  res_cc
);
	timeunit 1ns;
	timeprecision 1ps;

	// A stalled result keeps valid and all of its fields until the sink takes it.
	property result_held;
		@(posedge clk) disable iff (!rst_n)
		res_valid && !res_ready |=>
			res_valid && $stable(res_dr) && $stable(res_data) && $stable(res_cc);
	endproperty

	a_result_held: assert property (result_held)
		else $error("Result stream changed before it was accepted.");

	// Once the sink takes a result the unit waits for the next word.
	a_ready_after_result: assert property (@(posedge clk) disable iff (!rst_n)
		res_valid && res_ready |=> instr_ready)
		else $error("instr_ready did not rise after a result was accepted.");

	a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !res_valid)
		else $error("res_valid was high during reset.");

endmodule : exec_unit_chk

// File: test/exec_unit_tb.sv
module exec_unit_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_RANDOM     = 400;
	localparam int TIMEOUT_CYCLES = 12000;	// 408 words at up to 17 cycles, plus stalls.

	logic        clk;
	logic        rst_n;
	logic        instr_valid;
	logic        instr_ready;
	logic [15:0] instr;
	logic        res_valid;
	logic        res_ready;
	logic [2:0]  res_dr;
	logic [15:0] res_data;
	logic [2:0]  res_cc;
	logic [15:0] model_regs [8];	// Register file as the testbench expects it.
	logic [2:0]  model_cc;		// Condition code as the testbench expects it.
	int          cycles = 0;

	exec_unit i_exec_unit (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr_ready (instr_ready),
		.instr       (instr),
		.res_valid   (res_valid),
		.res_ready   (res_ready),
		.res_dr      (res_dr),
		.res_data    (res_data),
		.res_cc      (res_cc)
	);

	bind exec_unit exec_unit_chk i_exec_unit_chk (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_ready (instr_ready),
		.res_valid   (res_valid),
		.res_ready   (res_ready),
		.res_dr      (res_dr),
		.res_data    (res_data),
		.res_cc      (res_cc)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			stop_on_failure("Timeout: the run did not finish within the cycle limit.");
		end
	end

	task automatic stop_on_failure(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1, "Simulation stopped on the first error.");
	endtask

	task automatic check_value(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		assert (got === exp)
			else stop_on_failure($sformatf("ERR %0t %s got %h expected %h",
				$time, name, got, exp));
	endtask

	// The architectural condition code changes only on a result handshake.
	task automatic check_cc_register();
		check_value("cc", 16'(i_exec_unit.i_reg_state.cc), 16'(model_cc));
	endtask

	function automatic logic [2:0] expected_cc(input logic [15:0] v);
		logic [2:0] c;
		c = 3'b000;
		if (v[15]) c[lc3b_pkg::CC_N] = 1'b1;
		else if (v == 16'h0000) c[lc3b_pkg::CC_Z] = 1'b1;
		else c[lc3b_pkg::CC_P] = 1'b1;
		return c;
	endfunction

	// Operate semantics: sources from the model registers, imm5 sign-extended.
	function automatic logic [15:0] predict_result(input logic [15:0] w);
		logic [15:0] a;
		logic [15:0] b;
		a = model_regs[w[8:6]];
		b = w[5] ? {{11{w[4]}}, w[4:0]} : model_regs[w[2:0]];
		case (w[15:12])
			4'b0001: return a + b;
			4'b0101: return a & b;
			4'b1001: return ~a;
			default: begin
				if (!w[5]) return a << w[3:0];	// SLL
				else if (!w[4]) return a >> w[3:0];
				else return $signed(a) >>> w[3:0];	// SRA keeps the sign.
			end
		endcase
	endfunction

	function automatic logic [15:0] random_word();
		logic [3:0]  opcode;
		logic [11:0] rest;
		int          kind;
		kind = int'($urandom_range(0, 9));
		rest = 12'($urandom());
		case (kind)
			0, 1: opcode = 4'b0001;
			2, 3: opcode = 4'b0101;
			4: begin
				opcode    = 4'b1001;
				rest[5:0] = 6'b111111;
			end
			5, 6, 7: opcode = 4'b1101;
			default: begin
				opcode = 4'($urandom());
				while (opcode[1:0] == 2'b01) opcode = 4'($urandom());	// Any non-operate code.
			end
		endcase
		return {opcode, rest};
	endfunction

	task automatic send_and_check(input logic [15:0] w);
		logic        produces;
		logic [15:0] exp_data;
		int          exp_lat;
		int          lat;
		produces = (w[13:12] == 2'b01);	// The four operate opcodes all end in 01.
		exp_data = predict_result(w);
		exp_lat  = (w[15:12] == 4'b1101) ? 2 + int'(w[3:0]) : 2;
		if ($urandom_range(0, 3) == 0) @(negedge clk);
		instr_valid = 1'b1;
		instr       = w;
		check_value("instr_ready", 16'(instr_ready), 16'h0001);
		@(posedge clk);
		@(negedge clk);
		instr_valid = 1'b0;
		instr       = 16'($urandom());	// The unit must not look at the bus after acceptance.
		lat         = 1;
		if (!produces) begin
			while (!instr_ready) begin
				check_value("res_valid", 16'(res_valid), 16'h0000);
				@(negedge clk);
			end
			check_value("res_valid", 16'(res_valid), 16'h0000);
			check_cc_register();
		end else begin
			while (!res_valid) begin
				@(negedge clk);
				lat++;
			end
			assert (lat == exp_lat)
				else stop_on_failure($sformatf("ERR %0t latency got %0d expected %0d",
					$time, lat, exp_lat));
			res_ready = ($urandom_range(0, 9) < 7);	// About 70% ready.
			while (!res_ready) begin
				@(negedge clk);
				check_value("res_valid", 16'(res_valid), 16'h0001);
				res_ready = ($urandom_range(0, 9) < 7);
			end
			check_value("res_dr", 16'(res_dr), 16'(w[11:9]));
			check_value("res_data", res_data, exp_data);
			check_value("res_cc", 16'(res_cc), 16'(expected_cc(exp_data)));
			@(posedge clk);
			model_regs[w[11:9]] = exp_data;
			model_cc            = expected_cc(exp_data);
			@(negedge clk);
			res_ready = 1'b0;
			check_cc_register();
		end
	endtask

	initial begin
		logic [15:0] word;
		void'($urandom(90356));
		clk         = 1'b0;
		rst_n       = 1'b0;
		instr_valid = 1'b0;
		instr       = 16'h0000;
		res_ready   = 1'b0;
		for (int i = 0; i < 8; i++) model_regs[i] = 16'h0000;
		model_cc = expected_cc(16'h0000);
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		check_value("instr_ready", 16'(instr_ready), 16'h0001);
		check_value("res_valid", 16'(res_valid), 16'h0000);
		check_cc_register();
		// ADD Rn, Rn, #imm reads each register straight out of reset.
		for (int i = 0; i < 8; i++) begin
			word = {4'b0001, 3'(i), 3'(i), 1'b1, 5'($urandom())};
			send_and_check(word);
		end
		for (int n = 0; n < NUM_RANDOM; n++) begin
			word = random_word();
			send_and_check(word);
		end
		$display("** PASS **");
		$finish;
	end

endmodule : exec_unit_tb

// File: files.f
design/lc3b_pkg.sv
design/gen_control.sv
design/exec_sequencer.sv
design/shift_counter.sv
design/reg_state.sv
design/alu_shifter.sv
design/exec_unit.sv
test/exec_unit_chk.sv
test/exec_unit_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= exec_unit_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q -F "** PASS **" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
